//--- common/flash_loader_defines.svh
/*
 * Quad-SPI boot loader constants
 * Flash command, phase lengths and the sizes of the address, count and word fields
 */

`ifndef FLASH_LOADER_DEFINES_SVH
`define FLASH_LOADER_DEFINES_SVH

// Quad output fast read, address and command go out on io0 only
`define FLASH_CMD_QUAD_READ 8'h6B

// Flash clocks between the last address bit and the first data nibble
`define FLASH_DUMMY_CYCLES 8

`define FLASH_ADDR_BITS 24
`define FLASH_WORD_BYTES 4

// Width of the word count in a request and of the RAM word index
`define FLASH_COUNT_BITS 16

`endif

//--- common/flash_loader_pkg.sv
/*
 * Shared types of the quad-SPI boot loader
 * Sequencer phases plus the request, pin and RAM write bundles
 */

`default_nettype none

`include "flash_loader_defines.svh"

package flash_loader_pkg;

    // Phases of one load, in the order the sequencer walks them
    typedef enum logic [2:0] {
        qspi_idle,
        qspi_select,
        qspi_command,
        qspi_address,
        qspi_dummy,
        qspi_data,
        qspi_deselect
    } qspi_state_t;

    // Load request, only sampled together with start
    typedef struct packed {
        logic [`FLASH_ADDR_BITS-1:0]  addr;
        logic [`FLASH_COUNT_BITS-1:0] word_count;
    } load_req_t;

    // Flash pin bundle, clk_ddr[0] is the high half and clk_ddr[1] the low half of a cycle
    typedef struct packed {
        logic       csn;
        logic [1:0] clk_ddr;
        logic [3:0] io_out;
        logic [3:0] io_out_en;
    } flash_pins_t;

    // One word for the CPU RAM write port
    typedef struct packed {
        logic [8*`FLASH_WORD_BYTES-1:0] data;
        logic [`FLASH_COUNT_BITS-1:0]   index;
    } ram_write_t;

endpackage

`default_nettype wire

//--- src/flash_io_regs.sv
/*
 * Flash pin register stage
 * One clock of delay with a chosen reset value, for any pin bundle type
 */

`timescale 1ns/100ps
`default_nettype none

module flash_io_regs #(
    parameter type      payload_t   = logic [3:0],
    parameter payload_t reset_value = '0
) (
    input  wire      clk_2x,
    input  wire      rst_n,
    input  payload_t d,
    output payload_t q
);

    // This stage sets the pin timing, both directions see exactly one cycle here
    always_ff @(posedge clk_2x) begin
        if (!rst_n) begin
            // Pins come out of reset in their idle levels, for outputs that means csn high
            q <= reset_value;
        end else begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- qspi/qspi_cycle_counter.sv
/*
 * Phase and word counters for the quad-SPI sequencer
 * Flags the last cycle of a phase and the last word of a load
 */

`timescale 1ns/100ps
`default_nettype none

`include "flash_loader_defines.svh"

module qspi_cycle_counter (
    input  wire                          clk_2x,
    input  wire                          rst_n,
    input  wire                          phase_load,
    input  wire [7:0]                    phase_len,
    input  wire                          word_load,
    input  wire [`FLASH_COUNT_BITS-1:0]  word_count,
    input  wire                          word_done,
    output logic                         phase_last,
    output logic                         words_last
);
    logic [7:0]                   phase_cnt;
    logic [`FLASH_COUNT_BITS-1:0] word_cnt;

    always_ff @(posedge clk_2x) begin
        if (!rst_n) begin
            phase_cnt <= 8'd0;
            word_cnt  <= '0;
        end else begin
            // Loaded with length minus one so that zero marks the final cycle
            if (phase_load) phase_cnt <= phase_len - 8'd1;
            else if (phase_cnt != 8'd0) phase_cnt <= phase_cnt - 8'd1;

            if (word_load) word_cnt <= word_count;
            else if (word_done) word_cnt <= word_cnt - 1'b1;
        end
    end

    assign phase_last = (phase_cnt == 8'd0);
    assign words_last = (word_cnt == `FLASH_COUNT_BITS'(1));

    // Shifter must not report more words than the request asked for
    assert property (@(posedge clk_2x) disable iff (!rst_n)
        word_done |-> word_cnt != '0);

endmodule

`default_nettype wire

//--- qspi/qspi_sequencer.sv
/*
 * Quad-SPI read sequencer
 * Walks select, command, address, dummy and data phases for one load request
 */

`timescale 1ns/100ps
`default_nettype none

`include "flash_loader_defines.svh"

module qspi_sequencer (
    input  wire                          clk_2x,
    input  wire                          rst_n,
    input  wire                          start,
    input  wire                          phase_last,
    input  wire                          words_last,
    input  wire                          word_done,
    output flash_loader_pkg::qspi_state_t state,
    output logic                         phase_load,
    output logic [7:0]                   phase_len,
    output logic                         word_load,
    output logic                         load_shift,
    output logic                         data_enable,
    output logic                         busy,
    output logic                         done
);
    import flash_loader_pkg::*;

    qspi_state_t next_state;

    // Next phase and the counter loads that go with entering it
    always_comb begin
        next_state = state;
        phase_load = 1'b0;
        phase_len  = 8'd0;
        word_load  = 1'b0;
        load_shift = 1'b0;
        case (state)
            qspi_idle: begin
                // Request is only valid with start, so latch everything here
                if (start) begin
                    next_state = qspi_select;
                    phase_load = 1'b1;
                    phase_len  = 8'd1;
                    word_load  = 1'b1;
                    load_shift = 1'b1;
                end
            end
            qspi_select: begin
                if (phase_last) begin
                    next_state = qspi_command;
                    phase_load = 1'b1;
                    phase_len  = 8'($bits(`FLASH_CMD_QUAD_READ));
                end
            end
            qspi_command: begin
                if (phase_last) begin
                    next_state = qspi_address;
                    phase_load = 1'b1;
                    phase_len  = 8'(`FLASH_ADDR_BITS);
                end
            end
            qspi_address: begin
                if (phase_last) begin
                    next_state = qspi_dummy;
                    phase_load = 1'b1;
                    phase_len  = 8'(`FLASH_DUMMY_CYCLES);
                end
            end
            qspi_dummy: begin
                if (phase_last) next_state = qspi_data;
            end
            qspi_data: begin
                // The word count rather than the phase counter decides the end
                if (word_done && words_last) next_state = qspi_deselect;
            end
            qspi_deselect: next_state = qspi_idle;
            default: next_state = qspi_idle;
        endcase
    end

    always_ff @(posedge clk_2x) begin
        if (!rst_n) begin
            state <= qspi_idle;
            done  <= 1'b0;
        end else begin
            state <= next_state;
            // One pulse as the deselect phase closes while csn is already high at the pins
            done  <= (state == qspi_deselect);
        end
    end

    assign data_enable = (state == qspi_data);
    assign busy        = (state != qspi_idle);

    // A start seen mid-load must not reload the request latches or cut a phase short
    assert property (@(posedge clk_2x) disable iff (!rst_n)
        start && busy |-> !word_load && !load_shift && (!phase_load || phase_last));

endmodule

`default_nettype wire

//--- qspi/qspi_shifter.sv
/*
 * Quad-SPI data path
 * Sends command and address on io0, then packs returned nibbles into RAM words
 */

`timescale 1ns/100ps
`default_nettype none

`include "flash_loader_defines.svh"

module qspi_shifter (
    input  wire                           clk_2x,
    input  wire                           rst_n,
    input  flash_loader_pkg::qspi_state_t state,
    input  wire                           load_shift,
    input  wire                           data_enable,
    input  flash_loader_pkg::load_req_t   req,
    input  wire [3:0]                     io_in_q,
    output flash_loader_pkg::flash_pins_t pins_raw,
    output logic                          ram_we,
    output flash_loader_pkg::ram_write_t  ram_wr,
    output logic                          word_done
);
    import flash_loader_pkg::*;

    localparam int shift_bits = $bits(`FLASH_CMD_QUAD_READ) + `FLASH_ADDR_BITS;
    localparam int word_bits  = 8 * `FLASH_WORD_BYTES;
    localparam int nib_bits   = $clog2(2 * `FLASH_WORD_BYTES);

    logic [shift_bits-1:0]        shift_q;
    logic [1:0]                   data_en_q;
    logic [nib_bits-1:0]          nib_cnt;
    logic [word_bits-1:0]         word_acc;
    logic [word_bits-1:0]         word_next;
    logic [`FLASH_COUNT_BITS-1:0] wr_index;
    logic                         drive_io0;

    // Flash is driven from select until the address is out, then released
    assign drive_io0 = (state == qspi_select) || (state == qspi_command) ||
                       (state == qspi_address);

    always_comb begin
        pins_raw.csn       = (state == qspi_idle) || (state == qspi_deselect);
        pins_raw.clk_ddr   = 2'b00;
        pins_raw.io_out    = 4'h0;
        pins_raw.io_out_en = 4'h0;
        // Clock high in the first half of each cycle while bits move
        if (!pins_raw.csn && state != qspi_select) pins_raw.clk_ddr = 2'b01;
        if (drive_io0) begin
            pins_raw.io_out    = {3'b000, shift_q[shift_bits-1]};
            pins_raw.io_out_en = 4'b0001;
        end
    end

    // High nibble of each byte comes first, bytes fill the word from bit 0 up
    always_comb begin
        word_next = word_acc;
        word_next[{nib_cnt[nib_bits-1:1], ~nib_cnt[0], 2'b00} +: 4] = io_in_q;
    end

    // Two cycle delay matches the output and input pin register stages
    assign word_done = data_en_q[1] && (nib_cnt == '1);

    always_ff @(posedge clk_2x) begin
        if (!rst_n) begin
            data_en_q <= 2'b00;
            nib_cnt   <= '0;
            wr_index  <= '0;
            ram_we    <= 1'b0;
        end else begin
            data_en_q <= {data_en_q[0], data_enable};
            ram_we    <= word_done;
            if (load_shift) begin
                nib_cnt  <= '0;
                wr_index <= '0;
            end else begin
                if (data_en_q[1]) nib_cnt <= nib_cnt + 1'b1;
                if (word_done) wr_index <= wr_index + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_2x) begin
        // Command byte and address go out MSB first as one 32 bit stream
        if (load_shift) shift_q <= {`FLASH_CMD_QUAD_READ, req.addr};
        else if (state == qspi_command || state == qspi_address) shift_q <= shift_q << 1;
        if (data_en_q[1]) word_acc <= word_next;
        if (word_done) begin
            ram_wr.data  <= word_next;
            ram_wr.index <= wr_index;
        end
    end

    // Captured nibbles must never come from our own drivers
    assert property (@(posedge clk_2x) disable iff (!rst_n)
        data_en_q[1] |-> pins_raw.io_out_en == 4'h0);

endmodule

`default_nettype wire

//--- src/flash_boot_loader.sv
/*
 * Quad-SPI flash boot loader
 * Copies a block of words from serial flash into a CPU RAM write port
 */

`timescale 1ns/100ps
`default_nettype none

`include "flash_loader_defines.svh"

module flash_boot_loader (
    input  wire                           clk_2x,
    input  wire                           rst_n,
    input  wire                           start,
    input  flash_loader_pkg::load_req_t   req,
    input  wire [3:0]                     io_in,
    output logic                          busy,
    output logic                          done,
    output logic                          ram_we,
    output flash_loader_pkg::ram_write_t  ram_wr,
    output flash_loader_pkg::flash_pins_t pins
);
    import flash_loader_pkg::*;

    // Deselected flash with a stopped clock and all drivers off
    localparam flash_pins_t pins_idle = '{csn: 1'b1, clk_ddr: 2'b00, io_out: 4'h0, io_out_en: 4'h0};

    qspi_state_t state;
    flash_pins_t pins_raw;
    logic        phase_load, word_load, load_shift, data_enable;
    logic [7:0]  phase_len;
    logic        phase_last, words_last, word_done;
    logic [3:0]  io_in_q;

    qspi_sequencer qspi_sequencer_inst (
        .clk_2x(clk_2x), .rst_n(rst_n), .start(start),
        .phase_last(phase_last), .words_last(words_last), .word_done(word_done),
        .state(state), .phase_load(phase_load), .phase_len(phase_len),
        .word_load(word_load), .load_shift(load_shift), .data_enable(data_enable),
        .busy(busy), .done(done)
    );

    qspi_cycle_counter qspi_cycle_counter_inst (
        .clk_2x(clk_2x), .rst_n(rst_n),
        .phase_load(phase_load), .phase_len(phase_len),
        .word_load(word_load), .word_count(req.word_count), .word_done(word_done),
        .phase_last(phase_last), .words_last(words_last)
    );

    qspi_shifter qspi_shifter_inst (
        .clk_2x(clk_2x), .rst_n(rst_n), .state(state), .load_shift(load_shift),
        .data_enable(data_enable), .req(req), .io_in_q(io_in_q),
        .pins_raw(pins_raw), .ram_we(ram_we), .ram_wr(ram_wr), .word_done(word_done)
    );

    // Outgoing pins, adds the second cycle from start to csn low
    flash_io_regs #(.payload_t(flash_pins_t), .reset_value(pins_idle)) pins_out_regs (
        .clk_2x(clk_2x), .rst_n(rst_n), .d(pins_raw), .q(pins)
    );

    // Incoming nibbles, part of the fixed two cycle capture delay
    flash_io_regs #(.payload_t(logic [3:0]), .reset_value(4'h0)) io_in_regs (
        .clk_2x(clk_2x), .rst_n(rst_n), .d(io_in), .q(io_in_q)
    );

endmodule

`default_nettype wire

//--- bench/flash_model.sv
/*
 * Behavioural quad-SPI flash
 * Decodes the read command and address on the rebuilt clock and returns pattern bytes
 */

`timescale 1ns/100ps
`default_nettype none

`include "flash_loader_defines.svh"

module flash_model (
    input  wire         csn,
    input  wire         sclk,
    input  wire  [3:0]  io_drv,
    input  wire  [3:0]  io_drv_en,
    output logic [3:0]  io_q,
    output logic [15:0] cmd_count,
    output logic [7:0]  last_cmd,
    output logic [23:0] last_addr,
    output logic [15:0] bus_errors
);
    // Command byte plus address, all on io0
    localparam int header_clocks = 8 + `FLASH_ADDR_BITS;

    int unsigned rise_cnt;
    logic [31:0] shift_in;
    logic [23:0] rd_addr;
    logic [7:0]  out_byte;
    logic        high_nibble;

    // Array content, low address byte XOR A5 plus the top address byte
    function automatic logic [7:0] array_byte(input logic [23:0] a);
        return (a[7:0] ^ 8'hA5) + a[23:16];
    endfunction

    initial begin
        io_q        = 4'h0;
        cmd_count   = 16'd0;
        last_cmd    = 8'h00;
        last_addr   = 24'h0;
        bus_errors  = 16'd0;
        rise_cnt    = 0;
        shift_in    = 32'h0;
        high_nibble = 1'b1;
    end

    // Every select starts a new command
    always @(negedge csn) begin
        rise_cnt    = 0;
        high_nibble = 1'b1;
    end

    // Host bits are taken on the rising flash clock
    always @(posedge sclk) begin
        if (!csn) begin
            if (rise_cnt < header_clocks) begin
                // The host has to drive io0 for every header bit
                if (io_drv_en[0] !== 1'b1) bus_errors = bus_errors + 16'd1;
                shift_in = {shift_in[30:0], io_drv[0]};
            end
            rise_cnt = rise_cnt + 1;
            if (rise_cnt == header_clocks) begin
                cmd_count = cmd_count + 16'd1;
                last_cmd  = shift_in[31:24];
                last_addr = shift_in[23:0];
                rd_addr   = shift_in[23:0];
            end
        end
    end

    // After the dummy clocks one nibble leaves per falling edge, high nibble first
    always @(negedge sclk) begin
        if (!csn && rise_cnt > header_clocks + `FLASH_DUMMY_CYCLES) begin
            if (io_drv_en != 4'h0) bus_errors = bus_errors + 16'd1;
            out_byte = array_byte(rd_addr);
            if (high_nibble) begin
                io_q = out_byte[7:4];
            end else begin
                io_q    = out_byte[3:0];
                rd_addr = rd_addr + 24'd1;
            end
            high_nibble = ~high_nibble;
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_flash_boot_loader.sv
/*
 * Testbench for the quad-SPI flash boot loader
 * Random loads against a behavioural flash, words checked against the content rule
 */

`timescale 1ns/100ps
`default_nettype none

module tb_flash_boot_loader;
    import flash_loader_pkg::*;

    localparam int random_loads = 10;
    localparam int load_total   = random_loads + 2;

    logic        clk_2x = 1'b0;
    logic        rst_n;
    logic        start;
    load_req_t   req;
    logic [3:0]  io_in;
    logic        busy;
    logic        done;
    logic        ram_we;
    ram_write_t  ram_wr;
    flash_pins_t pins;
    logic        sclk = 1'b0;
    logic [15:0] cmd_count;
    logic [15:0] bus_errors;
    logic [7:0]  last_cmd;
    logic [23:0] last_addr;

    logic [15:0] lfsr = 16'd11835;
    logic [23:0] load_addr [load_total];
    int          load_words [load_total];
    int          watchdog_cycles = 0;
    string       test_name;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errors = 0;
    int          test_errors_start;
    logic [31:0] strobe_data [$];
    logic [15:0] strobe_index [$];

    always #10 clk_2x = ~clk_2x;

    // Flash clock from the DDR pair, taken once the pin register has settled
    always @(posedge clk_2x) begin
        #1;
        sclk = pins.clk_ddr[0];
    end

    always @(negedge clk_2x) begin
        #1;
        sclk = pins.clk_ddr[1];
    end

    flash_boot_loader flash_boot_loader_inst (
        .clk_2x(clk_2x), .rst_n(rst_n), .start(start), .req(req), .io_in(io_in),
        .busy(busy), .done(done), .ram_we(ram_we), .ram_wr(ram_wr), .pins(pins)
    );

    flash_model flash_model_inst (
        .csn(pins.csn), .sclk(sclk), .io_drv(pins.io_out), .io_drv_en(pins.io_out_en),
        .io_q(io_in), .cmd_count(cmd_count), .last_cmd(last_cmd), .last_addr(last_addr),
        .bus_errors(bus_errors)
    );

    // Every RAM strobe is kept for the running test
    always @(negedge clk_2x) begin
        if (rst_n && ram_we) begin
            strobe_data.push_back(ram_wr.data);
            strobe_index.push_back(ram_wr.index);
        end
    end

    // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [7:0] pattern_byte(input logic [23:0] a);
        return (a[7:0] ^ 8'hA5) + a[23:16];
    endfunction

    // Four consecutive flash bytes, the lowest address lands in bits 7:0
    function automatic logic [31:0] pattern_word(input logic [23:0] base, input int k);
        logic [31:0] w;
        for (int i = 0; i < 4; i++)
            w[8*i +: 8] = pattern_byte(base + 24'(4 * k + i));
        return w;
    endfunction

    task automatic check_eq(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s: %s expected %0h actual %0h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic open_test(input string name);
        test_name         = name;
        test_errors_start = errors;
    endtask

    task automatic close_test();
        tests_run++;
        if (errors == test_errors_start) begin
            $display("PASS %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", test_name, errors - test_errors_start);
        end
    endtask

    // One complete load, optionally with a second start while the first is running
    task automatic run_load(input logic [23:0] addr, input int words, input bit extra_start);
        int          cycles;
        bit          done_seen;
        logic [15:0] cmd_before;
        cmd_before = cmd_count;
        cycles     = 0;
        done_seen  = 1'b0;
        strobe_data.delete();
        strobe_index.delete();
        @(posedge clk_2x);
        #2;
        start          = 1'b1;
        req.addr       = addr;
        req.word_count = 16'(words);
        @(posedge clk_2x);
        #2;
        start = 1'b0;
        if (extra_start) begin
            // Other values on purpose, the loader must drop this request entirely
            repeat (10) @(posedge clk_2x);
            #2;
            check_eq("busy at second start", 1, busy);
            start          = 1'b1;
            req.addr       = ~addr;
            req.word_count = 16'd3;
            @(posedge clk_2x);
            #2;
            start  = 1'b0;
            cycles = 12;
        end
        while (!done_seen && cycles < words * 8 + 50) begin
            @(negedge clk_2x);
            cycles++;
            done_seen = done;
        end
        assert (done_seen) else begin
            $display("Test %s: load never signalled done within %0d cycles", test_name, cycles);
            errors++;
        end
        check_eq("csn at done", 1, pins.csn);
        // Flash stays deselected with a stopped clock once the load is over
        repeat (3) begin
            @(negedge clk_2x);
            check_eq("busy after done", 0, busy);
            check_eq("csn after done", 1, pins.csn);
            check_eq("clk_ddr after done", 0, pins.clk_ddr);
            check_eq("flash clock after done", 0, sclk);
        end
        check_eq("strobe count", words, strobe_data.size());
        for (int k = 0; k < strobe_data.size(); k++) begin
            check_eq($sformatf("data of word %0d", k), pattern_word(addr, k), strobe_data[k]);
            check_eq($sformatf("index of word %0d", k), k, strobe_index[k]);
        end
        check_eq("command count", cmd_before + 16'd1, cmd_count);
        check_eq("command byte", 8'h6B, last_cmd);
        check_eq("address", addr, last_addr);
        check_eq("bus conflicts", 0, bus_errors);
    endtask

    initial begin
        int          total;
        logic [31:0] value;
        rst_n = 1'b0;
        start = 1'b0;
        req   = '0;
        // Whole load list up front, so the watchdog knows the run length
        load_addr[0]  = 24'h0;
        load_words[0] = 1;
        for (int i = 1; i < load_total; i++) begin
            take_bits(24, value);
            load_addr[i] = value[23:0];
            take_bits(3, value);
            load_words[i] = int'(value[2:0]) + 1;
        end
        total = 0;
        for (int i = 0; i < load_total; i++)
            total += load_words[i] * 8 + 50;
        watchdog_cycles = 2 * total;

        repeat (3) @(posedge clk_2x);
        #2;
        rst_n = 1'b1;

        open_test("reset_idle");
        repeat (10) begin
            @(negedge clk_2x);
            check_eq("csn", 1, pins.csn);
            check_eq("busy", 0, busy);
            check_eq("done", 0, done);
            check_eq("ram_we", 0, ram_we);
            check_eq("io_out_en", 0, pins.io_out_en);
        end
        close_test();

        open_test("single_word");
        run_load(load_addr[0], load_words[0], 1'b0);
        close_test();

        for (int i = 1; i <= random_loads; i++) begin
            open_test($sformatf("random_load_%0d", i));
            run_load(load_addr[i], load_words[i], 1'b0);
            close_test();
        end

        open_test("start_while_busy");
        run_load(load_addr[load_total-1], load_words[load_total-1], 1'b1);
        close_test();

        $display("Tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk_2x);
        $display("Watchdog: run still going after %0d cycles", watchdog_cycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+common
common/flash_loader_pkg.sv
src/flash_io_regs.sv
qspi/qspi_cycle_counter.sv
qspi/qspi_sequencer.sv
qspi/qspi_shifter.sv
src/flash_boot_loader.sv
bench/flash_model.sv
bench/tb_flash_boot_loader.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_flash_boot_loader
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Result: PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
